/* verilog/rvfi_cmp_cfg.svh */
//**************************************************************************
// Build-time sizes for the RVFI lockstep trace checker.
// Included by the package and by every module that needs a width,
// and by the testbench to size its own models.
//**************************************************************************

`ifndef RVFI_CMP_CFG_SVH
`define RVFI_CMP_CFG_SVH

// Width of pc, insn, register data, memory address and memory data
`define RVFI_CMP_XLEN 32

// Default depth of the core retirement alignment queue
`define RVFI_CMP_FIFO_DEPTH 4

// Width of the retirement counter, wraps around
`define RVFI_CMP_CNT_W 16

`endif

/* verilog/rvfi_cmp_pkg.sv */
//**************************************************************************
// Shared types of the RVFI lockstep trace checker: one retirement trace,
// the compared field and error kinds, the first-failure record and the
// monitor FSM states. Referenced by scoped names only.
//**************************************************************************

`include "rvfi_cmp_cfg.svh"

package rvfi_cmp_pkg;

  // One instruction retirement as seen on RVFI
  typedef struct packed {
    logic [`RVFI_CMP_XLEN-1:0]   pc_rdata;
    logic [`RVFI_CMP_XLEN-1:0]   insn;
    logic                        trap;
    logic                        intr;
    logic [1:0]                  mode;
    logic [4:0]                  rd1_addr;
    logic [`RVFI_CMP_XLEN-1:0]   rd1_wdata;
    logic [`RVFI_CMP_XLEN-1:0]   mem_addr;
    logic [`RVFI_CMP_XLEN/8-1:0] mem_rmask;
    logic [`RVFI_CMP_XLEN/8-1:0] mem_wmask;
    logic [`RVFI_CMP_XLEN-1:0]   mem_wdata;
    logic [`RVFI_CMP_XLEN-1:0]   mem_rdata;
  } rvfi_trace_t;

  // Compared fields, listed in reporting priority
  typedef enum logic [3:0] {
    FLD_NONE, FLD_INSN, FLD_TRAP, FLD_INTR, FLD_MODE, FLD_PC, FLD_RD_ADDR,
    FLD_RD_WDATA, FLD_MEM_RMASK, FLD_MEM_WMASK, FLD_MEM_ADDR,
    FLD_MEM_WDATA, FLD_MEM_RDATA
  } rvfi_field_e;

  typedef enum logic [1:0] {
    ERR_NONE, ERR_FIELD, ERR_ORPHAN, ERR_OVERFLOW
  } rvfi_err_kind_e;

  // Captured on the first failure only
  typedef struct packed {
    rvfi_err_kind_e            kind;
    rvfi_field_e               field;
    logic [`RVFI_CMP_XLEN-1:0] pc;
    logic [`RVFI_CMP_XLEN-1:0] expected;
    logic [`RVFI_CMP_XLEN-1:0] actual;
  } rvfi_fail_t;

  typedef enum logic {MON_RUN, MON_FAILED} rvfi_mon_state_e;

endpackage

/* verilog/rvfi_trace_align.sv */
//**************************************************************************
// Alignment queue for core retirements. Each core retirement is pushed,
// each model retirement pops the head. Flags model retirements that find
// the queue empty and pushes dropped on a full queue.
//**************************************************************************

`timescale 1ns/1ps

`include "rvfi_cmp_cfg.svh"

module rvfi_trace_align #(
  parameter int DEPTH = `RVFI_CMP_FIFO_DEPTH
) (
  input  logic                         rvfi_core,
  input  logic                         arst_n_i,
  input  logic                         core_valid_i,
  input  logic                         rm_valid_i,
  input  rvfi_cmp_pkg::rvfi_trace_t    core_trace_i,
  output rvfi_cmp_pkg::rvfi_trace_t    head_o,
  output logic                         pop_o,
  output logic                         orphan_o,
  output logic                         overflow_o,
  output logic [$clog2(DEPTH+1)-1:0]   level_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH+1);

  rvfi_cmp_pkg::rvfi_trace_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [LVL_W-1:0]          count;
  logic                      empty;
  logic                      full;
  logic                      push;

  assign empty = (count == '0);
  assign full  = (count == LVL_W'(DEPTH));

  // A pop frees a slot in the same cycle, so a full queue still accepts
  assign pop_o      = rm_valid_i && !empty;
  assign orphan_o   = rm_valid_i && empty;
  assign push       = core_valid_i && (!full || pop_o);
  assign overflow_o = core_valid_i && full && !pop_o;

  assign head_o  = mem[rd_ptr];
  assign level_o = count;

  always_ff @(posedge rvfi_core) begin
    if (push) begin
      mem[wr_ptr] <= core_trace_i;
    end
  end

  always_ff @(posedge rvfi_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_o) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + LVL_W'(push) - LVL_W'(pop_o);
    end
  end

endmodule

/* verilog/rvfi_field_compare.sv */
//**************************************************************************
// Combinational masked compare of a core trace against a model trace.
// Reports the highest-priority failing field with the model's value as
// expected and the core's value as actual, both zero-extended.
//**************************************************************************

`timescale 1ns/1ps

`include "rvfi_cmp_cfg.svh"

module rvfi_field_compare (
  input  rvfi_cmp_pkg::rvfi_trace_t   core_i,
  input  rvfi_cmp_pkg::rvfi_trace_t   rm_i,
  output rvfi_cmp_pkg::rvfi_field_e   field_o,
  output logic [`RVFI_CMP_XLEN-1:0]   expected_o,
  output logic [`RVFI_CMP_XLEN-1:0]   actual_o
);

  typedef logic [`RVFI_CMP_XLEN-1:0] word_t;

  word_t wlanes;
  word_t rlanes;
  word_t rm_wdata_m;
  word_t core_wdata_m;
  word_t rm_rdata_m;
  word_t core_rdata_m;
  logic  mem_active;
  logic  rd_written;

  // Byte lanes follow the core's masks
  always_comb begin
    for (int i = 0; i < `RVFI_CMP_XLEN/8; i++) begin
      wlanes[8*i +: 8] = {8{core_i.mem_wmask[i]}};
      rlanes[8*i +: 8] = {8{core_i.mem_rmask[i]}};
    end
  end

  assign rm_wdata_m   = rm_i.mem_wdata & wlanes;
  assign core_wdata_m = core_i.mem_wdata & wlanes;
  assign rm_rdata_m   = rm_i.mem_rdata & rlanes;
  assign core_rdata_m = core_i.mem_rdata & rlanes;

  assign mem_active = (core_i.mem_rmask != '0) || (core_i.mem_wmask != '0);
  // Writes to x0 carry no data worth checking
  assign rd_written = (rm_i.rd1_addr != 5'd0);

  always_comb begin
    field_o    = rvfi_cmp_pkg::FLD_NONE;
    expected_o = '0;
    actual_o   = '0;
    if (rm_i.insn != core_i.insn) begin
      field_o    = rvfi_cmp_pkg::FLD_INSN;
      expected_o = rm_i.insn;
      actual_o   = core_i.insn;
    end else if (rm_i.trap != core_i.trap) begin
      field_o    = rvfi_cmp_pkg::FLD_TRAP;
      expected_o = word_t'(rm_i.trap);
      actual_o   = word_t'(core_i.trap);
    end else if (rm_i.intr != core_i.intr) begin
      field_o    = rvfi_cmp_pkg::FLD_INTR;
      expected_o = word_t'(rm_i.intr);
      actual_o   = word_t'(core_i.intr);
    end else if (rm_i.mode != core_i.mode) begin
      field_o    = rvfi_cmp_pkg::FLD_MODE;
      expected_o = word_t'(rm_i.mode);
      actual_o   = word_t'(core_i.mode);
    end else if (rm_i.pc_rdata != core_i.pc_rdata) begin
      field_o    = rvfi_cmp_pkg::FLD_PC;
      expected_o = rm_i.pc_rdata;
      actual_o   = core_i.pc_rdata;
    end else if (rm_i.rd1_addr != core_i.rd1_addr) begin
      field_o    = rvfi_cmp_pkg::FLD_RD_ADDR;
      expected_o = word_t'(rm_i.rd1_addr);
      actual_o   = word_t'(core_i.rd1_addr);
    end else if (rd_written && (rm_i.rd1_wdata != core_i.rd1_wdata)) begin
      field_o    = rvfi_cmp_pkg::FLD_RD_WDATA;
      expected_o = rm_i.rd1_wdata;
      actual_o   = core_i.rd1_wdata;
    end else if (rm_i.mem_rmask != core_i.mem_rmask) begin
      field_o    = rvfi_cmp_pkg::FLD_MEM_RMASK;
      expected_o = word_t'(rm_i.mem_rmask);
      actual_o   = word_t'(core_i.mem_rmask);
    end else if (rm_i.mem_wmask != core_i.mem_wmask) begin
      field_o    = rvfi_cmp_pkg::FLD_MEM_WMASK;
      expected_o = word_t'(rm_i.mem_wmask);
      actual_o   = word_t'(core_i.mem_wmask);
    end else if (mem_active && (rm_i.mem_addr != core_i.mem_addr)) begin
      field_o    = rvfi_cmp_pkg::FLD_MEM_ADDR;
      expected_o = rm_i.mem_addr;
      actual_o   = core_i.mem_addr;
    end else if (rm_wdata_m != core_wdata_m) begin
      field_o    = rvfi_cmp_pkg::FLD_MEM_WDATA;
      expected_o = rm_wdata_m;
      actual_o   = core_wdata_m;
    end else if (rm_rdata_m != core_rdata_m) begin
      field_o    = rvfi_cmp_pkg::FLD_MEM_RDATA;
      expected_o = rm_rdata_m;
      actual_o   = core_rdata_m;
    end
  end

endmodule

/* verilog/rvfi_cmp_monitor.sv */
//**************************************************************************
// Verdict register of the trace checker. Pulses match or mismatch one
// cycle after each event, counts popped retirements, and holds a sticky
// error with a frozen record of the first failure until reset.
//**************************************************************************

`timescale 1ns/1ps

`include "rvfi_cmp_cfg.svh"

module rvfi_cmp_monitor (
  input  logic                           rvfi_core,
  input  logic                           arst_n_i,
  input  logic                           pop_i,
  input  logic                           orphan_i,
  input  logic                           overflow_i,
  input  rvfi_cmp_pkg::rvfi_field_e      field_i,
  input  logic [`RVFI_CMP_XLEN-1:0]      expected_i,
  input  logic [`RVFI_CMP_XLEN-1:0]      actual_i,
  input  logic [`RVFI_CMP_XLEN-1:0]      rm_pc_i,
  output logic                           match_o,
  output logic                           mismatch_o,
  output logic                           error_o,
  output rvfi_cmp_pkg::rvfi_fail_t       first_fail_o,
  output logic [`RVFI_CMP_CNT_W-1:0]     retire_cnt_o
);

  rvfi_cmp_pkg::rvfi_mon_state_e state;
  rvfi_cmp_pkg::rvfi_fail_t      fail_rec;
  logic                          field_bad;
  logic                          fail_now;

  assign field_bad = pop_i && (field_i != rvfi_cmp_pkg::FLD_NONE);
  // Orphan, overflow and pop never coincide, so one event per cycle
  assign fail_now  = field_bad || orphan_i || overflow_i;

  always_comb begin
    fail_rec = '0;
    if (orphan_i) begin
      fail_rec.kind = rvfi_cmp_pkg::ERR_ORPHAN;
      fail_rec.pc   = rm_pc_i;
    end else if (overflow_i) begin
      fail_rec.kind = rvfi_cmp_pkg::ERR_OVERFLOW;
    end else if (field_bad) begin
      fail_rec.kind     = rvfi_cmp_pkg::ERR_FIELD;
      fail_rec.field    = field_i;
      fail_rec.pc       = rm_pc_i;
      fail_rec.expected = expected_i;
      fail_rec.actual   = actual_i;
    end
  end

  assign error_o = (state == rvfi_cmp_pkg::MON_FAILED);

  always_ff @(posedge rvfi_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state        <= rvfi_cmp_pkg::MON_RUN;
      match_o      <= 1'b0;
      mismatch_o   <= 1'b0;
      first_fail_o <= '0;
      retire_cnt_o <= '0;
    end else begin
      match_o      <= pop_i && !field_bad;
      mismatch_o   <= fail_now;
      retire_cnt_o <= retire_cnt_o + `RVFI_CMP_CNT_W'(pop_i);
      // Only the first failure is recorded
      if ((state == rvfi_cmp_pkg::MON_RUN) && fail_now) begin
        state        <= rvfi_cmp_pkg::MON_FAILED;
        first_fail_o <= fail_rec;
      end
    end
  end

endmodule

/* verilog/rvfi_cmp_top.sv */
//**************************************************************************
// Top level of the RVFI lockstep trace checker. Core retirements wait in
// the alignment queue; each model retirement is compared against the
// queue head and the monitor reports the verdict.
//**************************************************************************

`timescale 1ns/1ps

`include "rvfi_cmp_cfg.svh"

module rvfi_cmp_top (
  input  logic                                      rvfi_core,
  input  logic                                      arst_n_i,
  input  logic                                      core_valid_i,
  input  logic                                      rm_valid_i,
  input  rvfi_cmp_pkg::rvfi_trace_t                 core_trace_i,
  input  rvfi_cmp_pkg::rvfi_trace_t                 rm_trace_i,
  output logic                                      match_o,
  output logic                                      mismatch_o,
  output logic                                      error_o,
  output rvfi_cmp_pkg::rvfi_fail_t                  first_fail_o,
  output logic [`RVFI_CMP_CNT_W-1:0]                retire_cnt_o,
  output logic [$clog2(`RVFI_CMP_FIFO_DEPTH+1)-1:0] level_o
);

  rvfi_cmp_pkg::rvfi_trace_t head;
  rvfi_cmp_pkg::rvfi_field_e field;
  logic [`RVFI_CMP_XLEN-1:0] expected;
  logic [`RVFI_CMP_XLEN-1:0] actual;
  logic                      pop;
  logic                      orphan;
  logic                      overflow;

  rvfi_trace_align #(.DEPTH(`RVFI_CMP_FIFO_DEPTH)) u_align (
    .rvfi_core(rvfi_core), .arst_n_i(arst_n_i),
    .core_valid_i(core_valid_i), .rm_valid_i(rm_valid_i),
    .core_trace_i(core_trace_i), .head_o(head),
    .pop_o(pop), .orphan_o(orphan), .overflow_o(overflow), .level_o(level_o)
  );

  rvfi_field_compare u_compare (
    .core_i(head), .rm_i(rm_trace_i),
    .field_o(field), .expected_o(expected), .actual_o(actual)
  );

  rvfi_cmp_monitor u_monitor (
    .rvfi_core(rvfi_core), .arst_n_i(arst_n_i),
    .pop_i(pop), .orphan_i(orphan), .overflow_i(overflow),
    .field_i(field), .expected_i(expected), .actual_i(actual),
    .rm_pc_i(rm_trace_i.pc_rdata),
    .match_o(match_o), .mismatch_o(mismatch_o), .error_o(error_o),
    .first_fail_o(first_fail_o), .retire_cnt_o(retire_cnt_o)
  );

endmodule

/* tests/rvfi_cmp_properties.sv */
//**************************************************************************
// Concurrent checks on the trace checker outputs. Bound into the top
// level, so the testbench needs no extra wiring.
//**************************************************************************

`timescale 1ns/1ps

module rvfi_cmp_properties (
  input logic                     rvfi_core,
  input logic                     arst_n_i,
  input logic                     match_i,
  input logic                     mismatch_i,
  input logic                     error_i,
  input rvfi_cmp_pkg::rvfi_fail_t first_fail_i
);

  // Set by any failing property
  logic failed = 1'b0;

  a_one_verdict: assert property (@(posedge rvfi_core) disable iff (!arst_n_i)
    !(match_i && mismatch_i))
    else begin
      $error("match and mismatch high in the same cycle");
      failed = 1'b1;
    end

  // Only a reset may clear the sticky error
  a_error_sticky: assert property (@(posedge rvfi_core) disable iff (!arst_n_i)
    !$fell(error_i))
    else begin
      $error("error dropped without a reset");
      failed = 1'b1;
    end

  a_record_frozen: assert property (@(posedge rvfi_core) disable iff (!arst_n_i)
    ($past(error_i) && error_i) |-> $stable(first_fail_i))
    else begin
      $error("first failure record changed while error was set");
      failed = 1'b1;
    end

endmodule

bind rvfi_cmp_top rvfi_cmp_properties u_props (
  .rvfi_core(rvfi_core), .arst_n_i(arst_n_i), .match_i(match_o),
  .mismatch_i(mismatch_o), .error_i(error_o), .first_fail_i(first_fail_o)
);

/* tests/rvfi_cmp_tb.sv */
//**************************************************************************
// Table-driven testbench for the RVFI trace checker. Pairs core and model
// traces at lags of 0 to 3 cycles, predicts each verdict with a queue
// scoreboard and checks all DUT outputs after every verdict pulse.
//**************************************************************************

`timescale 1ns/1ps

`include "rvfi_cmp_cfg.svh"

module rvfi_cmp_tb;

  localparam int DEPTH   = `RVFI_CMP_FIFO_DEPTH;
  localparam int TIMEOUT = 16;

  // Mutation of the model trace, idle cycles before it retires, expected field
  typedef struct packed {
    logic [3:0]                mut;
    logic [1:0]                lag;
    rvfi_cmp_pkg::rvfi_field_e fld;
  } case_t;

  logic                       rvfi_core;
  logic                       arst_n_i;
  logic                       core_valid_i;
  logic                       rm_valid_i;
  rvfi_cmp_pkg::rvfi_trace_t  core_trace_i;
  rvfi_cmp_pkg::rvfi_trace_t  rm_trace_i;
  logic                       match_o;
  logic                       mismatch_o;
  logic                       error_o;
  rvfi_cmp_pkg::rvfi_fail_t   first_fail_o;
  logic [`RVFI_CMP_CNT_W-1:0] retire_cnt_o;
  logic [$clog2(DEPTH+1)-1:0] level_o;

  // Scoreboard state
  rvfi_cmp_pkg::rvfi_trace_t  sb_q [$];
  rvfi_cmp_pkg::rvfi_fail_t   sb_fail;
  logic                       sb_err;
  logic [`RVFI_CMP_CNT_W-1:0] sb_cnt;

  // 1 to 5 change insn, trap, intr, mode, pc; 6 and 7 hit masked rd1_wdata
  // and mem_addr; 8 and 9 a byte outside the mask, 10 and 11 one inside
  case_t cases [15] = '{
    '{4'd0, 2'd0, rvfi_cmp_pkg::FLD_NONE}, '{4'd0, 2'd1, rvfi_cmp_pkg::FLD_NONE},
    '{4'd0, 2'd2, rvfi_cmp_pkg::FLD_NONE}, '{4'd0, 2'd3, rvfi_cmp_pkg::FLD_NONE},
    '{4'd1, 2'd1, rvfi_cmp_pkg::FLD_INSN}, '{4'd2, 2'd0, rvfi_cmp_pkg::FLD_TRAP},
    '{4'd3, 2'd2, rvfi_cmp_pkg::FLD_INTR}, '{4'd4, 2'd3, rvfi_cmp_pkg::FLD_MODE},
    '{4'd5, 2'd1, rvfi_cmp_pkg::FLD_PC},   '{4'd6, 2'd0, rvfi_cmp_pkg::FLD_NONE},
    '{4'd7, 2'd2, rvfi_cmp_pkg::FLD_NONE}, '{4'd8, 2'd1, rvfi_cmp_pkg::FLD_NONE},
    '{4'd9, 2'd3, rvfi_cmp_pkg::FLD_NONE},
    '{4'd10, 2'd0, rvfi_cmp_pkg::FLD_MEM_WDATA},
    '{4'd11, 2'd2, rvfi_cmp_pkg::FLD_MEM_RDATA}
  };

  rvfi_cmp_top dut0 (
    .rvfi_core(rvfi_core), .arst_n_i(arst_n_i),
    .core_valid_i(core_valid_i), .rm_valid_i(rm_valid_i),
    .core_trace_i(core_trace_i), .rm_trace_i(rm_trace_i),
    .match_o(match_o), .mismatch_o(mismatch_o), .error_o(error_o),
    .first_fail_o(first_fail_o), .retire_cnt_o(retire_cnt_o), .level_o(level_o)
  );

  always #2 rvfi_core = ~rvfi_core;

  // A failing bound property ends the run as well
  always @(posedge dut0.u_props.failed) begin
    $display("A bound property on the DUT outputs failed");
    abort_run();
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] byte_lanes(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // Model value and core value of one field, masked lanes zeroed
  function automatic void field_values(input rvfi_cmp_pkg::rvfi_field_e f,
                                       input rvfi_cmp_pkg::rvfi_trace_t core,
                                       input rvfi_cmp_pkg::rvfi_trace_t rm,
                                       output logic [31:0] e, output logic [31:0] a);
    logic [31:0] wl;
    logic [31:0] rl;
    wl = byte_lanes(core.mem_wmask);
    rl = byte_lanes(core.mem_rmask);
    case (f)
      rvfi_cmp_pkg::FLD_INSN:      {e, a} = {rm.insn, core.insn};
      rvfi_cmp_pkg::FLD_TRAP:      {e, a} = {31'd0, rm.trap, 31'd0, core.trap};
      rvfi_cmp_pkg::FLD_INTR:      {e, a} = {31'd0, rm.intr, 31'd0, core.intr};
      rvfi_cmp_pkg::FLD_MODE:      {e, a} = {30'd0, rm.mode, 30'd0, core.mode};
      rvfi_cmp_pkg::FLD_PC:        {e, a} = {rm.pc_rdata, core.pc_rdata};
      rvfi_cmp_pkg::FLD_MEM_WDATA: {e, a} = {rm.mem_wdata & wl, core.mem_wdata & wl};
      rvfi_cmp_pkg::FLD_MEM_RDATA: {e, a} = {rm.mem_rdata & rl, core.mem_rdata & rl};
      default:                     {e, a} = '0;
    endcase
  endfunction

  task automatic record_fail(input rvfi_cmp_pkg::rvfi_fail_t rec);
    if (!sb_err) begin
      sb_fail = rec;
      sb_err  = 1'b1;
    end
  endtask

  task automatic drive(input logic cv, input rvfi_cmp_pkg::rvfi_trace_t ct,
                       input logic rv, input rvfi_cmp_pkg::rvfi_trace_t rt);
    @(posedge rvfi_core);
    core_valid_i <= cv;
    core_trace_i <= ct;
    rm_valid_i   <= rv;
    rm_trace_i   <= rt;
  endtask

  task automatic push_core(input rvfi_cmp_pkg::rvfi_trace_t t, output logic over);
    drive(1'b1, t, 1'b0, '0);
    over = (sb_q.size() == DEPTH);
    if (over) begin
      record_fail('{kind: rvfi_cmp_pkg::ERR_OVERFLOW, field: rvfi_cmp_pkg::FLD_NONE,
                    pc: '0, expected: '0, actual: '0});
    end else begin
      sb_q.push_back(t);
    end
  endtask

  task automatic retire_model(input rvfi_cmp_pkg::rvfi_trace_t t,
                              input rvfi_cmp_pkg::rvfi_field_e fld, output logic bad);
    rvfi_cmp_pkg::rvfi_trace_t head;
    logic [31:0]               e;
    logic [31:0]               a;
    drive(1'b0, '0, 1'b1, t);
    bad = (sb_q.size() == 0) || (fld != rvfi_cmp_pkg::FLD_NONE);
    if (sb_q.size() == 0) begin
      record_fail('{kind: rvfi_cmp_pkg::ERR_ORPHAN, field: rvfi_cmp_pkg::FLD_NONE,
                    pc: t.pc_rdata, expected: '0, actual: '0});
    end else begin
      head   = sb_q.pop_front();
      sb_cnt = sb_cnt + 1'b1;
      field_values(fld, head, t, e, a);
      if (bad) begin
        record_fail('{kind: rvfi_cmp_pkg::ERR_FIELD, field: fld, pc: t.pc_rdata,
                      expected: e, actual: a});
      end
    end
  endtask

  task automatic check_state();
    check_val("error_o", error_o, sb_err);
    check_val("first_fail_o.kind", first_fail_o.kind, sb_fail.kind);
    check_val("first_fail_o.field", first_fail_o.field, sb_fail.field);
    check_val("first_fail_o.pc", first_fail_o.pc, sb_fail.pc);
    check_val("first_fail_o.expected", first_fail_o.expected, sb_fail.expected);
    check_val("first_fail_o.actual", first_fail_o.actual, sb_fail.actual);
    check_val("retire_cnt_o", retire_cnt_o, sb_cnt);
    check_val("level_o", level_o, sb_q.size());
  endtask

  // Waits for the verdict pulse of the last sampled event
  task automatic wait_verdict(input logic exp_bad);
    int n;
    n = 0;
    drive(1'b0, '0, 1'b0, '0);
    @(negedge rvfi_core);
    while (!match_o && !mismatch_o && n < TIMEOUT) begin
      n++;
      @(negedge rvfi_core);
    end
    if (!match_o && !mismatch_o) begin
      $display("Timeout: no match or mismatch pulse within %0d cycles", TIMEOUT);
      abort_run();
    end else begin
      check_val("match_o", match_o, !exp_bad);
      check_val("mismatch_o", mismatch_o, exp_bad);
      check_state();
      // Verdict pulses last one cycle
      @(negedge rvfi_core);
      check_val("match_o", match_o, 1'b0);
      check_val("mismatch_o", mismatch_o, 1'b0);
    end
  endtask

  task automatic reset_dut();
    @(posedge rvfi_core);
    arst_n_i     <= 1'b0;
    core_valid_i <= 1'b0;
    rm_valid_i   <= 1'b0;
    repeat (3) @(posedge rvfi_core);
    arst_n_i <= 1'b1;
    sb_q.delete();
    sb_cnt  = '0;
    sb_err  = 1'b0;
    sb_fail = '0;
    @(negedge rvfi_core);
    check_val("match_o", match_o, 1'b0);
    check_val("mismatch_o", mismatch_o, 1'b0);
    check_state();
  endtask

  task automatic build_pair(input logic [3:0] mut, output rvfi_cmp_pkg::rvfi_trace_t core,
                            output rvfi_cmp_pkg::rvfi_trace_t rm);
    logic [31:0] r;
    r = $urandom();
    core.pc_rdata  = $urandom();
    core.insn      = $urandom();
    core.rd1_wdata = $urandom();
    core.mem_addr  = $urandom();
    core.mem_wdata = $urandom();
    core.mem_rdata = $urandom();
    {core.trap, core.intr, core.mode, core.rd1_addr, core.mem_rmask, core.mem_wmask} = r[16:0];
    case (mut)
      4'd6:        core.rd1_addr = 5'd0;
      4'd7:        {core.mem_rmask, core.mem_wmask} = 8'h00;
      4'd8, 4'd10: {core.mem_rmask, core.mem_wmask} = 8'h03;
      4'd9, 4'd11: {core.mem_rmask, core.mem_wmask} = 8'h30;
      default:     ;
    endcase
    rm = core;
    case (mut)
      4'd1:    rm.insn = ~rm.insn;
      4'd2:    rm.trap = ~rm.trap;
      4'd3:    rm.intr = ~rm.intr;
      4'd4:    rm.mode = rm.mode + 2'd1;
      4'd5:    rm.pc_rdata = rm.pc_rdata + 32'd4;
      4'd6:    rm.rd1_wdata = ~rm.rd1_wdata;
      4'd7:    rm.mem_addr = ~rm.mem_addr;
      4'd8:    rm.mem_wdata[31:24] = ~rm.mem_wdata[31:24];
      4'd9:    rm.mem_rdata[31:24] = ~rm.mem_rdata[31:24];
      4'd10:   rm.mem_wdata[7:0] = ~rm.mem_wdata[7:0];
      4'd11:   rm.mem_rdata[15:8] = ~rm.mem_rdata[15:8];
      default: ;
    endcase
  endtask

  task automatic run_case(input case_t c);
    rvfi_cmp_pkg::rvfi_trace_t core;
    rvfi_cmp_pkg::rvfi_trace_t rm;
    logic                      over;
    logic                      bad;
    build_pair(c.mut, core, rm);
    push_core(core, over);
    repeat (c.lag) drive(1'b0, '0, 1'b0, '0);
    retire_model(rm, c.fld, bad);
    wait_verdict(bad);
  endtask

  initial begin
    rvfi_cmp_pkg::rvfi_trace_t core;
    rvfi_cmp_pkg::rvfi_trace_t rm;
    logic                      over;
    logic                      bad;
    rvfi_core    = 1'b0;
    arst_n_i     = 1'b0;
    core_valid_i = 1'b0;
    rm_valid_i   = 1'b0;
    core_trace_i = '0;
    rm_trace_i   = '0;
    void'($urandom(32'hca6d_610e));
    reset_dut();
    foreach (cases[i]) begin
      run_case(cases[i]);
      if (sb_err) begin
        reset_dut();
      end
    end
    // Orphan first, then a field error that must not replace its record
    build_pair(4'd0, core, rm);
    retire_model(rm, rvfi_cmp_pkg::FLD_NONE, bad);
    wait_verdict(bad);
    run_case(cases[4]);
    reset_dut();
    // One push more than the queue holds
    for (int k = 0; k <= DEPTH; k++) begin
      build_pair(4'd0, core, rm);
      push_core(core, over);
    end
    wait_verdict(over);
    reset_dut();
    $display("TEST OK");
    $finish;
  end

endmodule

/* files.f */
+incdir+verilog
verilog/rvfi_cmp_pkg.sv
verilog/rvfi_trace_align.sv
verilog/rvfi_field_compare.sv
verilog/rvfi_cmp_monitor.sv
verilog/rvfi_cmp_top.sv
tests/rvfi_cmp_properties.sv
tests/rvfi_cmp_tb.sv

/* Bender.yml */
package:
  name: rvfi_cmp

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rvfi_cmp_pkg.sv
      - verilog/rvfi_trace_align.sv
      - verilog/rvfi_field_compare.sv
      - verilog/rvfi_cmp_monitor.sv
      - verilog/rvfi_cmp_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/rvfi_cmp_properties.sv
      - tests/rvfi_cmp_tb.sv
